// File: mc_pkg.sv
package mc_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    localparam logic [DATA_W-1:0] PC_STEP  = 32'd4;
    localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0000;

    // Primary opcodes that the core executes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_LUI   = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRAV = 6'h07,
        FN_ADD  = 6'h20,
        FN_SUB  = 6'h22,
        FN_AND  = 6'h24,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT} alu_op_e;

    typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_SHIFT, WB_LUI} wb_sel_e;

    typedef enum logic [1:0] {ST_FETCH, ST_DECODE, ST_EXECUTE, ST_WRITEBACK} state_e;

    // I-type imm is {rd, shamt, funct}, J target is the low 26 bits
    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [SHAMT_W-1:0]    shamt;
        logic [5:0]            funct;
    } instr_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;   // ALU B is imm
        shift_op_e shift_op;
        logic      shift_var; // Amount from rs
        wb_sel_e   wb_sel;
        logic      dest_rd;   // Else rt
        logic      reg_we;
    } exec_ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0]  rs_val;
        logic [DATA_W-1:0]  rt_val;
        logic [DATA_W-1:0]  imm;
        logic [SHAMT_W-1:0] shamt;
    } operands_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     data;
        logic [DATA_W-1:0]     pc;
    } commit_t;

endpackage

// File: mc_regfile.sv
`timescale 1ns/100ps

module mc_regfile (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [mc_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [mc_pkg::REG_ADDR_W-1:0] rt_addr,
    output logic [mc_pkg::DATA_W-1:0]     rs_val,
    output logic [mc_pkg::DATA_W-1:0]     rt_val,
    input  logic                          wr_en,
    input  logic [mc_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [mc_pkg::DATA_W-1:0]     wr_data
);
    import mc_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // r0 is never written so it reads zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];

endmodule

// File: mc_alu.sv
`timescale 1ns/100ps

module mc_alu (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      exec_en,
    input  mc_pkg::exec_ctrl_t        ctrl,
    input  mc_pkg::operands_t         operands,
    output logic [mc_pkg::DATA_W-1:0] alu_result,
    output logic                      alu_zero
);
    import mc_pkg::*;

    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] result_d;
    logic              is_less;

    assign op_b    = ctrl.use_imm ? operands.imm : operands.rt_val;
    assign is_less = $signed(operands.rs_val) < $signed(op_b);

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result_d = operands.rs_val + op_b;
            ALU_SUB: result_d = operands.rs_val - op_b;
            ALU_AND: result_d = operands.rs_val & op_b;
            ALU_SLT: result_d = {{(DATA_W-1){1'b0}}, is_less};
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_result <= '0;
            alu_zero   <= 1'b0;
        end else if (exec_en) begin
            alu_result <= result_d;
            alu_zero   <= (result_d == '0); // Branch compare
        end
    end

endmodule

// File: mc_shifter.sv
`timescale 1ns/100ps

module mc_shifter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      exec_en,
    input  mc_pkg::exec_ctrl_t        ctrl,
    input  mc_pkg::operands_t         operands,
    output logic [mc_pkg::DATA_W-1:0] shift_result
);
    import mc_pkg::*;

    logic [SHAMT_W-1:0] amt;
    logic [DATA_W-1:0]  shift_d;

    // Variable shifts take rs[4:0]
    assign amt = ctrl.shift_var ? operands.rs_val[SHAMT_W-1:0] : operands.shamt;

    always_comb begin
        case (ctrl.shift_op)
            SH_SLL:  shift_d = operands.rt_val << amt;
            SH_SRL:  shift_d = operands.rt_val >> amt;
            SH_SRA:  shift_d = $unsigned($signed(operands.rt_val) >>> amt);
            default: shift_d = operands.rt_val;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_result <= '0;
        end else if (exec_en) begin
            shift_result <= shift_d;
        end
    end

endmodule

// File: mc_writeback.sv
`timescale 1ns/100ps

module mc_writeback (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wb_en,
    input  mc_pkg::exec_ctrl_t            ctrl,
    input  mc_pkg::instr_t                instr,
    input  logic [mc_pkg::DATA_W-1:0]     instr_pc,
    input  logic [mc_pkg::DATA_W-1:0]     alu_result,
    input  logic [mc_pkg::DATA_W-1:0]     shift_result,
    output logic                          wr_en,
    output logic [mc_pkg::REG_ADDR_W-1:0] wr_addr,
    output logic [mc_pkg::DATA_W-1:0]     wr_data,
    output logic                          commit_valid,
    output mc_pkg::commit_t               commit
);
    import mc_pkg::*;

    logic                  wb_en_q;
    logic                  fire;
    logic [DATA_W-1:0]     lui_val;
    logic [DATA_W-1:0]     result;
    logic [REG_ADDR_W-1:0] dest;

    // One commit per wb_en pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= wb_en;
        end
    end

    assign fire    = wb_en && !wb_en_q;
    assign lui_val = {instr.rd, instr.shamt, instr.funct, 16'h0000};
    assign dest    = ctrl.dest_rd ? instr.rd : instr.rt;

    always_comb begin
        case (ctrl.wb_sel)
            WB_SHIFT: result = shift_result;
            WB_LUI:   result = lui_val;
            default:  result = alu_result;
        endcase
    end

    assign wr_en   = fire && ctrl.reg_we;
    assign wr_addr = dest;
    assign wr_data = result;

    // Non-writing instructions report zeros
    assign commit_valid = fire;
    assign commit.we    = ctrl.reg_we;
    assign commit.rd    = ctrl.reg_we ? dest : '0;
    assign commit.data  = ctrl.reg_we ? result : '0;
    assign commit.pc    = instr_pc;

endmodule

// File: mc_ctrl.sv
`timescale 1ns/100ps

module mc_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    output logic [mc_pkg::DATA_W-1:0]     imem_addr,
    input  logic [mc_pkg::DATA_W-1:0]     imem_data,
    output logic [mc_pkg::REG_ADDR_W-1:0] rs_addr,
    output logic [mc_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [mc_pkg::DATA_W-1:0]     rs_val,
    input  logic [mc_pkg::DATA_W-1:0]     rt_val,
    output mc_pkg::operands_t             operands,
    output mc_pkg::exec_ctrl_t            ctrl,
    output mc_pkg::instr_t                instr,
    output logic                          exec_en,
    output logic                          wb_en,
    input  logic                          alu_zero,
    output logic [mc_pkg::DATA_W-1:0]     instr_pc
);
    import mc_pkg::*;

    state_e            state;
    logic [DATA_W-1:0] pc;
    instr_t            ir;
    exec_ctrl_t        dec;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] pc_plus4;
    logic [DATA_W-1:0] br_target;
    logic [DATA_W-1:0] jmp_target;
    logic [DATA_W-1:0] next_pc;

    assign imem_addr = pc;
    assign instr_pc  = pc;
    assign instr     = ir;
    assign rs_addr   = ir.rs;
    assign rt_addr   = ir.rt;

    assign imm_sext = {{(DATA_W-16){ir.rd[REG_ADDR_W-1]}}, ir.rd, ir.shamt, ir.funct};

    // Unknown codes fall through as no-op
    always_comb begin
        dec.alu_op    = ALU_ADD;
        dec.use_imm   = 1'b0;
        dec.shift_op  = SH_SLL;
        dec.shift_var = 1'b0;
        dec.wb_sel    = WB_ALU;
        dec.dest_rd   = 1'b0;
        dec.reg_we    = 1'b0;
        case (ir.opcode)
            OP_RTYPE: begin
                dec.dest_rd = 1'b1;
                dec.reg_we  = 1'b1;
                case (ir.funct)
                    FN_ADD: dec.alu_op = ALU_ADD;
                    FN_SUB: dec.alu_op = ALU_SUB;
                    FN_AND: dec.alu_op = ALU_AND;
                    FN_SLT: dec.alu_op = ALU_SLT;
                    FN_SLL: begin
                        dec.wb_sel   = WB_SHIFT;
                        dec.shift_op = SH_SLL;
                    end
                    FN_SRL: begin
                        dec.wb_sel   = WB_SHIFT;
                        dec.shift_op = SH_SRL;
                    end
                    FN_SRA: begin
                        dec.wb_sel   = WB_SHIFT;
                        dec.shift_op = SH_SRA;
                    end
                    FN_SLLV: begin
                        dec.wb_sel    = WB_SHIFT;
                        dec.shift_op  = SH_SLL;
                        dec.shift_var = 1'b1;
                    end
                    FN_SRAV: begin
                        dec.wb_sel    = WB_SHIFT;
                        dec.shift_op  = SH_SRA;
                        dec.shift_var = 1'b1;
                    end
                    default: begin
                        dec.dest_rd = 1'b0;
                        dec.reg_we  = 1'b0;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            OP_SLTI: begin
                dec.alu_op  = ALU_SLT;
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            OP_LUI: begin
                dec.wb_sel = WB_LUI;
                dec.reg_we = 1'b1;
            end
            OP_BEQ, OP_BNE: dec.alu_op = ALU_SUB; // Compare via zero flag
            default: ;
        endcase
    end

    // Next PC is sampled only in writeback when alu_zero is valid
    assign pc_plus4   = pc + PC_STEP;
    assign br_target  = pc_plus4 + {imm_sext[DATA_W-3:0], 2'b00};
    assign jmp_target = {pc_plus4[DATA_W-1:DATA_W-4], ir[25:0], 2'b00};

    always_comb begin
        next_pc = pc_plus4;
        case (ir.opcode)
            OP_BEQ:  if (alu_zero) next_pc = br_target;
            OP_BNE:  if (!alu_zero) next_pc = br_target;
            OP_J:    next_pc = jmp_target;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_FETCH;
            pc      <= RESET_PC;
            ctrl    <= '0;
            exec_en <= 1'b0;
            wb_en   <= 1'b0;
        end else begin
            exec_en <= (state == ST_DECODE);
            wb_en   <= (state == ST_EXECUTE);
            case (state)
                ST_FETCH:   state <= ST_DECODE;
                ST_DECODE: begin
                    state <= ST_EXECUTE;
                    ctrl  <= dec;
                end
                ST_EXECUTE: state <= ST_WRITEBACK;
                ST_WRITEBACK: begin
                    state <= ST_FETCH;
                    pc    <= next_pc;
                end
                default:    state <= ST_FETCH;
            endcase
        end
    end

    // IR and operand latches
    always_ff @(posedge clk) begin
        if (state == ST_FETCH) begin
            ir <= imem_data;
        end
        if (state == ST_DECODE) begin
            operands.rs_val <= rs_val;
            operands.rt_val <= rt_val;
            operands.imm    <= imm_sext;
            operands.shamt  <= ir.shamt;
        end
    end

endmodule

// File: mc_core.sv
`timescale 1ns/100ps

module mc_core (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic [mc_pkg::DATA_W-1:0] imem_addr,
    input  logic [mc_pkg::DATA_W-1:0] imem_data,
    output logic                      commit_valid,
    output mc_pkg::commit_t           commit
);
    import mc_pkg::*;

    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [DATA_W-1:0]     rs_val;
    logic [DATA_W-1:0]     rt_val;
    operands_t             operands;
    exec_ctrl_t            ctrl;
    instr_t                instr;
    logic                  exec_en;
    logic                  wb_en;
    logic                  alu_zero;
    logic [DATA_W-1:0]     instr_pc;
    logic [DATA_W-1:0]     alu_result;
    logic [DATA_W-1:0]     shift_result;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0]     wr_data;

    mc_ctrl mc_ctrl_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .operands  (operands),
        .ctrl      (ctrl),
        .instr     (instr),
        .exec_en   (exec_en),
        .wb_en     (wb_en),
        .alu_zero  (alu_zero),
        .instr_pc  (instr_pc)
    );

    mc_regfile mc_regfile_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    mc_alu mc_alu_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .exec_en    (exec_en),
        .ctrl       (ctrl),
        .operands   (operands),
        .alu_result (alu_result),
        .alu_zero   (alu_zero)
    );

    mc_shifter mc_shifter_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .exec_en      (exec_en),
        .ctrl         (ctrl),
        .operands     (operands),
        .shift_result (shift_result)
    );

    mc_writeback mc_writeback_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_en        (wb_en),
        .ctrl         (ctrl),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .alu_result   (alu_result),
        .shift_result (shift_result),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// File: tb_mc_cases.svh
`ifndef TB_MC_CASES_SVH
`define TB_MC_CASES_SVH

// Columns are name, word, runs, expected pc, we, rd, data
// Rows sit in address order; runs=0 marks a word that a branch or jump skips
task automatic load_cases();
    add_case("addi r1 imm 5", itype('h08, 0, 1, 5), 1, 0, 1, 1, 32'h0000_0005);
    add_case("addi r2 imm -3", itype('h08, 0, 2, -3), 1, 4, 1, 2, 32'hffff_fffd);
    add_case("addiu r3 r1+0x7ff0", itype('h09, 1, 3, 'h7ff0), 1, 8, 1, 3, 32'h0000_7ff5);
    add_case("slti r4 -3<1", itype('h0a, 2, 4, 1), 1, 12, 1, 4, 32'h0000_0001);
    add_case("slti r5 5<-1", itype('h0a, 1, 5, -1), 1, 16, 1, 5, 32'h0000_0000);
    add_case("lui r6 0x8001", itype('h0f, 0, 6, 'h8001), 1, 20, 1, 6, 32'h8001_0000);
    add_case("addi r0 discarded", itype('h08, 1, 0, 7), 1, 24, 1, 0, 32'h0000_000c);
    add_case("add r7 r0+r0", rtype(0, 0, 7, 0, 'h20), 1, 28, 1, 7, 32'h0000_0000);
    add_case("add r8 r1+r2", rtype(1, 2, 8, 0, 'h20), 1, 32, 1, 8, 32'h0000_0002);
    add_case("sub r9 r1-r3", rtype(1, 3, 9, 0, 'h22), 1, 36, 1, 9, 32'hffff_8010);
    add_case("and r10 r3&r9", rtype(3, 9, 10, 0, 'h24), 1, 40, 1, 10, 32'h0000_0010);
    add_case("slt r11 -3<5", rtype(2, 1, 11, 0, 'h2a), 1, 44, 1, 11, 32'h0000_0001);
    add_case("slt r12 5<-3", rtype(1, 2, 12, 0, 'h2a), 1, 48, 1, 12, 32'h0000_0000);

    // Shifts act on rt
    add_case("sll r13 r1<<4", rtype(0, 1, 13, 4, 'h00), 1, 52, 1, 13, 32'h0000_0050);
    add_case("srl r14 r6>>8", rtype(0, 6, 14, 8, 'h02), 1, 56, 1, 14, 32'h0080_0100);
    add_case("sra r15 r6>>>8", rtype(0, 6, 15, 8, 'h03), 1, 60, 1, 15, 32'hff80_0100);
    add_case("sllv r16 r3<<r1", rtype(1, 3, 16, 0, 'h04), 1, 64, 1, 16, 32'h000f_fea0);
    add_case("srav r17 r6>>>r9", rtype(9, 6, 17, 0, 'h07), 1, 68, 1, 17, 32'hffff_8001);

    add_case("beq not taken", itype('h04, 1, 2, 5), 1, 72, 0, 0, 32'h0);
    add_case("bne not taken", itype('h05, 1, 1, 5), 1, 76, 0, 0, 32'h0);
    add_case("beq taken +1", itype('h04, 7, 0, 1), 1, 80, 0, 0, 32'h0);
    add_case("after beq skipped", itype('h08, 0, 20, 'h111), 0, 84, 0, 0, 32'h0);
    add_case("bne taken +2", itype('h05, 1, 2, 2), 1, 88, 0, 0, 32'h0);
    add_case("after bne skipped a", itype('h08, 0, 20, 'h222), 0, 92, 0, 0, 32'h0);
    add_case("after bne skipped b", rtype(1, 1, 20, 0, 'h20), 0, 96, 0, 0, 32'h0);
    add_case("j to 0x70", jtype('h02, 28), 1, 100, 0, 0, 32'h0);
    add_case("after j skipped a", itype('h08, 0, 20, 'h333), 0, 104, 0, 0, 32'h0);
    add_case("after j skipped b", itype('h08, 0, 20, 'h444), 0, 108, 0, 0, 32'h0);
    add_case("unknown opcode", itype('h3f, 1, 2, 'h1234), 1, 112, 0, 0, 32'h0);
    add_case("add r18 r1+r1", rtype(1, 1, 18, 0, 'h20), 1, 116, 1, 18, 32'h0000_000a);
    add_case("unknown funct", rtype(1, 2, 21, 0, 'h25), 1, 120, 0, 0, 32'h0);
    add_case("add r19 r20 untouched", rtype(20, 0, 19, 0, 'h20), 1, 124, 1, 19, 32'h0);
endtask

`endif

// File: tb_mc_core.sv
`timescale 1ns/100ps

module tb_mc_core;
    import mc_pkg::*;

    localparam int CLK_HALF       = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int COMMIT_TIMEOUT = 20;
    localparam int FIRST_COMMIT   = 4;   // Cycle of the first commit after reset

    localparam logic [31:0] NOP_WORD = 32'hfc00_0000; // Opcode 0x3f is not kept

    typedef struct packed {
        logic [31:0] word;
        logic        runs;
        commit_t     exp;
    } case_t;

    logic              clk;
    logic              arst_n;
    logic [DATA_W-1:0] imem_addr;
    logic [DATA_W-1:0] imem_data;
    logic              commit_valid;
    commit_t           commit;

    case_t cases [$];
    string case_name [$];
    int    n_pass;
    int    n_fail;
    bit    timed_out;

    mc_core mc_core_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #CLK_HALF clk = ~clk;

    // Instruction word encoders
    function automatic logic [31:0] rtype(int rs, int rt, int rd, int sh, int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] itype(int op, int rs, int rt, int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jtype(int op, int target);
        return {6'(op), 26'(target)};
    endfunction

    task automatic add_case(string name, logic [31:0] word, bit runs, int pc, bit we,
                            int rd, logic [31:0] data);
        case_t c;
        c.word     = word;
        c.runs     = runs;
        c.exp.we   = we;
        c.exp.rd   = 5'(rd);
        c.exp.data = data;
        c.exp.pc   = 32'(pc);
        cases.push_back(c);
        case_name.push_back(name);
    endtask

    `include "tb_mc_cases.svh"

    function automatic logic [31:0] word_at(logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (!$isunknown(addr) && idx < cases.size()) begin
            return cases[idx].word;
        end
        return NOP_WORD; // Past the end of the table
    endfunction

    always @(negedge clk) begin
        imem_data <= word_at(imem_addr);
    end

    task automatic wait_commit(output bit seen);
        int cyc;
        seen = 1'b0;
        cyc  = 0;
        while (!seen && cyc < COMMIT_TIMEOUT) begin
            if (commit_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                cyc++;
            end
        end
    endtask

    // Called on the negedge that releases reset, which lies in cycle 1
    task automatic check_startup();
        int cyc;
        bit addr_ok;
        bit ok;
        cyc     = 1;
        addr_ok = 1'b1;
        ok      = 1'b1;
        while (commit_valid !== 1'b1 && cyc <= COMMIT_TIMEOUT) begin
            if (imem_addr !== RESET_PC) addr_ok = 1'b0;
            @(negedge clk);
            cyc++;
        end
        assert (commit_valid === 1'b1) else begin
            $display("Startup failed: no commit seen within %0d cycles of reset", COMMIT_TIMEOUT);
            ok        = 1'b0;
            timed_out = 1'b1;
        end
        assert (addr_ok) else begin
            $display("Startup failed: imem_addr left the reset PC before the first commit");
            ok = 1'b0;
        end
        assert (cyc == FIRST_COMMIT) else begin
            $display("Fail startup expected cycle %0d actual cycle %0d", FIRST_COMMIT, cyc);
            ok = 1'b0;
        end
        if (ok) begin
            $display("Pass startup");
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    task automatic check_row(int i);
        case_t c;
        bit    seen;
        c = cases[i];
        wait_commit(seen);
        assert (seen) else begin
            $display("Row %s failed: no commit within %0d cycles", case_name[i],
                     COMMIT_TIMEOUT);
            n_fail++;
            timed_out = 1'b1;
        end
        if (seen) begin
            assert (commit === c.exp) begin
                $display("Pass %s", case_name[i]);
                n_pass++;
            end else begin
                $write("Fail %s expected we=%0b rd=%0d data=%h pc=%h", case_name[i],
                       c.exp.we, c.exp.rd, c.exp.data, c.exp.pc);
                $display(" actual we=%0b rd=%0d data=%h pc=%h",
                         commit.we, commit.rd, commit.data, commit.pc);
                n_fail++;
            end
            @(negedge clk); // Step past this commit
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        imem_data = NOP_WORD;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 1'b0;
        load_cases();

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        check_startup();

        for (int i = 0; i < cases.size(); i++) begin
            if (cases[i].runs && !timed_out) check_row(i);
        end

        $display("Summary: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
mc_pkg.sv
mc_regfile.sv
mc_alu.sv
mc_shifter.sv
mc_writeback.sv
mc_ctrl.sv
mc_core.sv
tb_mc_core.sv
